// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tbMmuWalk
RTL_TOP    := mmuWalkTop
FILELIST   := flist.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := TEST PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== flist.f ====
logic/mmuPkg.sv
logic/tlbMissPort.sv
logic/pageWalker.sv
logic/pteLoadUnit.sv
logic/pageTableMem.sv
logic/mmuWalkTop.sv
verif/tbMmuWalk.sv

// ==== logic/mmuPkg.sv ====
`default_nettype none

package mmuPkg;

    typedef enum logic [1:0] {
        PRIV_USER       = 2'd0,
        PRIV_SUPERVISOR = 2'd1,
        PRIV_MACHINE    = 2'd3
    } PrivLevel;

    // doubles as the requester id on the result broadcast
    typedef enum logic [1:0] {
        RQ_IFETCH = 2'd0,
        RQ_STORE  = 2'd1,
        RQ_LOAD   = 2'd2
    } RqSource;

    typedef enum logic {
        IDLE,
        WAIT_FOR_LOAD
    } WalkState;

    localparam int NUM_RQS = 3;

    // Sv32 PTE flag bits
    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W = 2;
    localparam int PTE_X = 3;
    localparam int PTE_U = 4;
    localparam int PTE_A = 6;
    localparam int PTE_D = 7;

    localparam int PT_MEM_WORDS = 16384;  // 64 KB
    localparam int PT_ADDR_BITS = 14;

    localparam int unsigned LEGAL_ADDR_LIMIT = 65536;  // byte addresses below this are legal

    localparam int MEM_LATENCY = 2;  // cycles from load accept to result

endpackage

`default_nettype wire

// ==== logic/mmuWalkTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module mmuWalkTop (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             ifReq,
    input  wire [31:0]                      ifVaddr,
    input  wire [21:0]                      ifRootPpn,
    input  wire mmuPkg::PrivLevel           ifPriv,
    input  wire                             ifSum,
    input  wire                             ifMxr,
    input  wire                             stReq,
    input  wire [31:0]                      stVaddr,
    input  wire [21:0]                      stRootPpn,
    input  wire mmuPkg::PrivLevel           stPriv,
    input  wire                             stSum,
    input  wire                             stMxr,
    input  wire                             ldReq,
    input  wire [31:0]                      ldVaddr,
    input  wire [21:0]                      ldRootPpn,
    input  wire mmuPkg::PrivLevel           ldPriv,
    input  wire                             ldSum,
    input  wire                             ldMxr,
    output logic                            ifAck,
    output logic [21:0]                     ifPpn,
    output logic                            ifSuperPage,
    output logic                            ifPageFault,
    output logic                            stAck,
    output logic [21:0]                     stPpn,
    output logic                            stSuperPage,
    output logic                            stPageFault,
    output logic                            ldAck,
    output logic [21:0]                     ldPpn,
    output logic                            ldSuperPage,
    output logic                            ldPageFault,
    input  wire                             memWe,
    input  wire [mmuPkg::PT_ADDR_BITS-1:0]  memWaddr,
    input  wire [31:0]                      memWdata
);

    // index 0 is IFetch, 1 store, 2 load
    logic [0:mmuPkg::NUM_RQS-1]                   req, sum, mxr, ack, superPage, pageFault;
    logic [0:mmuPkg::NUM_RQS-1][31:0]             vaddr;
    logic [0:mmuPkg::NUM_RQS-1][21:0]             rootPpn, ppn;
    mmuPkg::PrivLevel [0:mmuPkg::NUM_RQS-1]       priv;
    logic [mmuPkg::NUM_RQS-1:0]                   rqValid, launch;
    logic [0:mmuPkg::NUM_RQS-1][31:0]             rqAddr;
    logic [0:mmuPkg::NUM_RQS-1][21:0]             rqRootPpn;
    mmuPkg::PrivLevel [0:mmuPkg::NUM_RQS-1]       rqPriv;
    logic [0:mmuPkg::NUM_RQS-1]                   rqSum, rqMxr;

    logic                            resValid, resSuperPage, resPageFault;
    mmuPkg::RqSource                 resRqId;
    logic [21:0]                     resPpn;
    logic [19:0]                     resVpn;
    logic                            ldValid, ldStall, ldResValid, rdEn;
    logic [31:0]                     ldAddr, ldResData, rdData;
    logic [mmuPkg::PT_ADDR_BITS-1:0] rdAddr;

    assign req = {ifReq, stReq, ldReq};
    assign sum = {ifSum, stSum, ldSum};
    assign mxr = {ifMxr, stMxr, ldMxr};
    assign vaddr = {ifVaddr, stVaddr, ldVaddr};
    assign rootPpn = {ifRootPpn, stRootPpn, ldRootPpn};
    assign priv[mmuPkg::RQ_IFETCH] = ifPriv;
    assign priv[mmuPkg::RQ_STORE] = stPriv;
    assign priv[mmuPkg::RQ_LOAD] = ldPriv;

    assign {ifAck, stAck, ldAck} = ack;
    assign {ifPpn, stPpn, ldPpn} = ppn;
    assign {ifSuperPage, stSuperPage, ldSuperPage} = superPage;
    assign {ifPageFault, stPageFault, ldPageFault} = pageFault;

    for (genvar i = 0; i < mmuPkg::NUM_RQS; i++) begin : gPort
        tlbMissPort #(
            .PORT_ID(mmuPkg::RqSource'(i))
        ) missPort (
            .clk, .rst,
            .req(req[i]), .vaddr(vaddr[i]), .rootPpn(rootPpn[i]),
            .priv(priv[i]), .sum(sum[i]), .mxr(mxr[i]),
            .launch(launch[i]),
            .resValid, .resRqId, .resPpn, .resSuperPage, .resPageFault,
            .ack(ack[i]), .rqValid(rqValid[i]), .rqAddr(rqAddr[i]),
            .rqRootPpn(rqRootPpn[i]), .rqPriv(rqPriv[i]), .rqSum(rqSum[i]),
            .rqMxr(rqMxr[i]),
            .ppn(ppn[i]), .superPage(superPage[i]), .pageFault(pageFault[i])
        );
    end

    pageWalker walker (
        .clk, .rst,
        .rqValid, .rqAddr, .rqRootPpn, .rqPriv, .rqSum, .rqMxr,
        .ldStall, .ldResValid, .ldResData,
        .launch, .resValid, .resRqId, .resPpn, .resVpn, .resSuperPage, .resPageFault,
        .ldValid, .ldAddr
    );

    pteLoadUnit loadUnit (
        .clk, .rst,
        .ldValid, .ldAddr, .rdData,
        .ldStall, .ldResValid, .ldResData, .rdEn, .rdAddr
    );

    pageTableMem ptMem (
        .clk, .rdEn, .rdAddr,
        .we(memWe), .wAddr(memWaddr), .wData(memWdata),
        .rdData
    );

    // the port holds its captured address until acked
    vpnMatchesRequest: assert property (@(posedge clk) disable iff (rst)
        resValid |-> resVpn == rqAddr[resRqId][31:12]);

endmodule

`default_nettype wire

// ==== logic/pageTableMem.sv ====
`timescale 1ns/100ps
`default_nettype none

module pageTableMem (
    input  wire                             clk,
    input  wire                             rdEn,
    input  wire [mmuPkg::PT_ADDR_BITS-1:0]  rdAddr,
    input  wire                             we,
    input  wire [mmuPkg::PT_ADDR_BITS-1:0]  wAddr,
    input  wire [31:0]                      wData,
    output logic [31:0]                     rdData
);

    logic [31:0] mem [mmuPkg::PT_MEM_WORDS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wAddr] <= wData;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

`default_nettype wire

// ==== logic/pageWalker.sv ====
`timescale 1ns/100ps
`default_nettype none

module pageWalker (
    input  wire                                         clk,
    input  wire                                         rst,
    input  wire [mmuPkg::NUM_RQS-1:0]                   rqValid,
    input  wire [0:mmuPkg::NUM_RQS-1][31:0]             rqAddr,
    input  wire [0:mmuPkg::NUM_RQS-1][21:0]             rqRootPpn,
    input  wire mmuPkg::PrivLevel [0:mmuPkg::NUM_RQS-1] rqPriv,
    input  wire [0:mmuPkg::NUM_RQS-1]                   rqSum,
    input  wire [0:mmuPkg::NUM_RQS-1]                   rqMxr,
    input  wire                                         ldStall,
    input  wire                                         ldResValid,
    input  wire [31:0]                                  ldResData,
    output logic [mmuPkg::NUM_RQS-1:0]                  launch,
    output logic                                        resValid,
    output mmuPkg::RqSource                             resRqId,
    output logic [21:0]                                 resPpn,
    output logic [19:0]                                 resVpn,
    output logic                                        resSuperPage,
    output logic                                        resPageFault,
    output logic                                        ldValid,
    output logic [31:0]                                 ldAddr
);

    mmuPkg::WalkState state;
    mmuPkg::PrivLevel privQ;
    mmuPkg::RqSource  rqId;
    mmuPkg::RqSource  selIdx;

    logic        walkIter;  // 1 while reading the level-1 PTE
    logic [19:0] walkVpn;
    logic        sumQ;
    logic        mxrQ;
    logic        selFound;
    logic        pageFaultC;

    wire [31:0] pte = ldResData;
    wire [2:0]  rwx = pte[mmuPkg::PTE_X:mmuPkg::PTE_R];
    wire [31:0] nextLookup = {pte[29:10], walkVpn[9:0], 2'b00};

    wire isPointer = (pte[3:0] == 4'b0001) && (pte[31:30] == 2'b00) && walkIter
        && (nextLookup < mmuPkg::LEGAL_ADDR_LIMIT);

    wire resultIn = (state == mmuPkg::WAIT_FOR_LOAD) && !ldValid && ldResValid;

    // highest index wins
    always_comb begin
        selFound = 1'b0;
        selIdx = mmuPkg::RQ_IFETCH;
        for (int i = 0; i < mmuPkg::NUM_RQS; i++) begin
            if (rqValid[i]) begin
                selFound = 1'b1;
                selIdx = mmuPkg::RqSource'(i);
            end
        end
    end

    always_comb begin
        launch = '0;
        if (state == mmuPkg::IDLE && selFound) begin
            launch[selIdx] = 1'b1;
        end
    end

    always_comb begin
        pageFaultC = 1'b0;

        if (!pte[mmuPkg::PTE_V] || !pte[mmuPkg::PTE_A]
            || (privQ == mmuPkg::PRIV_USER && !pte[mmuPkg::PTE_U])
            || (privQ == mmuPkg::PRIV_SUPERVISOR && pte[mmuPkg::PTE_U] && !sumQ)
            || (rqId == mmuPkg::RQ_STORE && !pte[mmuPkg::PTE_D])) begin
            pageFaultC = 1'b1;
        end

        // rwx is {X, W, R}
        case (rqId)
            mmuPkg::RQ_LOAD: begin
                case (rwx)
                    3'b001, 3'b011, 3'b101, 3'b111: ;
                    3'b100: pageFaultC = pageFaultC | !mxrQ;  // execute-only readable with MXR
                    default: pageFaultC = 1'b1;
                endcase
            end
            mmuPkg::RQ_STORE: begin
                case (rwx)
                    3'b011, 3'b111: ;
                    default: pageFaultC = 1'b1;
                endcase
            end
            default: begin
                case (rwx)
                    3'b100, 3'b101, 3'b111: ;
                    default: pageFaultC = 1'b1;
                endcase
            end
        endcase

        if (walkIter && pte[19:10] != 10'd0) begin
            pageFaultC = 1'b1;  // misaligned superpage
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mmuPkg::IDLE;
            ldValid <= 1'b0;
            resValid <= 1'b0;
        end else begin
            resValid <= 1'b0;
            case (state)
                mmuPkg::IDLE: begin
                    if (selFound) begin
                        state <= mmuPkg::WAIT_FOR_LOAD;
                        ldValid <= 1'b1;
                    end
                end
                default: begin
                    if (ldValid) begin
                        if (!ldStall) begin
                            ldValid <= 1'b0;
                        end
                    end else if (ldResValid) begin
                        if (isPointer) begin
                            ldValid <= 1'b1;  // go down to level 0
                        end else begin
                            resValid <= 1'b1;
                            state <= mmuPkg::IDLE;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mmuPkg::IDLE && selFound) begin
            walkIter <= 1'b1;
            walkVpn <= rqAddr[selIdx][31:12];
            sumQ <= rqSum[selIdx];
            mxrQ <= rqMxr[selIdx];
            privQ <= rqPriv[selIdx];
            rqId <= selIdx;
            ldAddr <= {rqRootPpn[selIdx][19:0], rqAddr[selIdx][31:22], 2'b00};
        end else if (resultIn) begin
            if (isPointer) begin
                ldAddr <= nextLookup;
                walkIter <= 1'b0;
            end else begin
                resRqId <= rqId;
                resPpn <= pte[31:10];
                resVpn <= walkVpn;
                resSuperPage <= walkIter;
                resPageFault <= pageFaultC;
            end
        end
    end

    noLoadInIdle: assert property (@(posedge clk) disable iff (rst)
        state == mmuPkg::IDLE |-> !ldValid);

    resultAfterLoad: assert property (@(posedge clk) disable iff (rst)
        resValid |-> $past(ldResValid));

endmodule

`default_nettype wire

// ==== logic/pteLoadUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module pteLoadUnit (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             ldValid,
    input  wire [31:0]                      ldAddr,
    input  wire [31:0]                      rdData,
    output logic                            ldStall,
    output logic                            ldResValid,
    output logic [31:0]                     ldResData,
    output logic                            rdEn,
    output logic [mmuPkg::PT_ADDR_BITS-1:0] rdAddr
);

    // one bit per stage of the single outstanding read
    logic [mmuPkg::MEM_LATENCY-1:0] validPipe;

    wire accept = ldValid && !ldStall;

    assign ldStall = |validPipe;
    assign ldResValid = validPipe[mmuPkg::MEM_LATENCY-1];

    assign rdEn = accept;
    assign rdAddr = ldAddr[mmuPkg::PT_ADDR_BITS+1:2];  // byte to word index

    always_ff @(posedge clk) begin
        if (rst) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[mmuPkg::MEM_LATENCY-2:0], accept};
        end
    end

    // RAM output holds until the next read, so one capture stage is enough
    always_ff @(posedge clk) begin
        if (validPipe[mmuPkg::MEM_LATENCY-2]) begin
            ldResData <= rdData;
        end
    end

    fixedLatency: assert property (@(posedge clk) disable iff (rst)
        accept |-> ##(mmuPkg::MEM_LATENCY) ldResValid);

endmodule

`default_nettype wire

// ==== logic/tlbMissPort.sv ====
`timescale 1ns/100ps
`default_nettype none

module tlbMissPort #(
    parameter mmuPkg::RqSource PORT_ID = mmuPkg::RQ_IFETCH
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     req,
    input  wire [31:0]              vaddr,
    input  wire [21:0]              rootPpn,
    input  wire mmuPkg::PrivLevel   priv,
    input  wire                     sum,
    input  wire                     mxr,
    input  wire                     launch,
    input  wire                     resValid,
    input  wire mmuPkg::RqSource    resRqId,
    input  wire [21:0]              resPpn,
    input  wire                     resSuperPage,
    input  wire                     resPageFault,
    output logic                    ack,
    output logic                    rqValid,
    output logic [31:0]             rqAddr,
    output logic [21:0]             rqRootPpn,
    output mmuPkg::PrivLevel        rqPriv,
    output logic                    rqSum,
    output logic                    rqMxr,
    output logic [21:0]             ppn,
    output logic                    superPage,
    output logic                    pageFault
);

    typedef enum logic [1:0] {
        PH_WAITING,
        PH_PENDING,
        PH_ACKED
    } PortPhase;

    PortPhase phase;

    wire resHit = resValid && (resRqId == PORT_ID);
    wire resTake = (phase == PH_PENDING) && resHit && !rqValid;  // only once launched

    assign ack = (phase == PH_ACKED);

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= PH_WAITING;
            rqValid <= 1'b0;
        end else begin
            case (phase)
                PH_WAITING: begin
                    if (req) begin
                        phase <= PH_PENDING;
                        rqValid <= 1'b1;
                    end
                end
                PH_PENDING: begin
                    if (launch) begin
                        rqValid <= 1'b0;  // walker has taken it
                    end
                    if (resTake) begin
                        phase <= PH_ACKED;
                    end
                end
                PH_ACKED: begin
                    if (!req) begin
                        phase <= PH_WAITING;
                    end
                end
                default: phase <= PH_WAITING;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == PH_WAITING && req) begin
            rqAddr <= vaddr;
            rqRootPpn <= rootPpn;
            rqPriv <= priv;
            rqSum <= sum;
            rqMxr <= mxr;
        end
        if (resTake) begin
            ppn <= resPpn;
            superPage <= resSuperPage;
            pageFault <= resPageFault;
        end
    end

    ackNeedsResult: assert property (@(posedge clk) disable iff (rst)
        ack |-> $past(ack) || $past(resHit));

endmodule

`default_nettype wire

// ==== verif/tbMmuWalk.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbMmuWalk;

    localparam int CYCLES_PER_TEST = 40;
    localparam string STIM_FILE = "verif/walkStim.txt";

    logic clk;
    logic rst;
    logic [2:0] reqs;  // bit index is the port id
    logic [31:0] vaddrs [3];
    logic [21:0] rootPpns [3];
    mmuPkg::PrivLevel privs [3];
    logic [2:0] sums;
    logic [2:0] mxrs;
    logic memWe;
    logic [mmuPkg::PT_ADDR_BITS-1:0] memWaddr;
    logic [31:0] memWdata;

    wire [2:0] acks;
    wire [21:0] ppnOut [3];
    wire [2:0] superOut;
    wire [2:0] faultOut;

    logic [21:0] expPpn [3];
    logic [2:0] expSuper;
    logic [2:0] expFault;
    int testIds [3];

    int cycleCount = 0;
    int cycleLimit;
    int testsRun;
    int testsFailed;
    int otherErrors;

    mmuWalkTop UUT (
        .clk, .rst,
        .ifReq(reqs[0]), .ifVaddr(vaddrs[0]), .ifRootPpn(rootPpns[0]),
        .ifPriv(privs[0]), .ifSum(sums[0]), .ifMxr(mxrs[0]),
        .stReq(reqs[1]), .stVaddr(vaddrs[1]), .stRootPpn(rootPpns[1]),
        .stPriv(privs[1]), .stSum(sums[1]), .stMxr(mxrs[1]),
        .ldReq(reqs[2]), .ldVaddr(vaddrs[2]), .ldRootPpn(rootPpns[2]),
        .ldPriv(privs[2]), .ldSum(sums[2]), .ldMxr(mxrs[2]),
        .ifAck(acks[0]), .ifPpn(ppnOut[0]), .ifSuperPage(superOut[0]), .ifPageFault(faultOut[0]),
        .stAck(acks[1]), .stPpn(ppnOut[1]), .stSuperPage(superOut[1]), .stPageFault(faultOut[1]),
        .ldAck(acks[2]), .ldPpn(ppnOut[2]), .ldSuperPage(superOut[2]), .ldPageFault(faultOut[2]),
        .memWe, .memWaddr, .memWdata
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #5;
    endtask

    task automatic countLines(output int nTests, output int nWrites);
        int fd;
        string line;
        nTests = 0;
        nWrites = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 0 && line[0] == "T") nTests++;
                else if (line.len() > 0 && line[0] == "W") nWrites++;
            end
            $fclose(fd);
        end
    endtask

    task automatic writeWord(input logic [31:0] byteAddr, input logic [31:0] data);
        memWe = 1'b1;
        memWaddr = byteAddr[mmuPkg::PT_ADDR_BITS+1:2];
        memWdata = data;
        nextCycle();
        memWe = 1'b0;
    endtask

    task automatic checkPort(input int p);
        int errs;
        errs = 0;
        assert (faultOut[p] === expFault[p]) else begin
            $display("FAIL %0t: test %0d port %0d pageFault %b, expected %b",
                $time, testIds[p], p, faultOut[p], expFault[p]);
            errs++;
        end
        // ppn and superPage carry no meaning on a fault
        if (!expFault[p]) begin
            assert (ppnOut[p] === expPpn[p]) else begin
                $display("FAIL %0t: test %0d port %0d ppn %h, expected %h",
                    $time, testIds[p], p, ppnOut[p], expPpn[p]);
                errs++;
            end
            assert (superOut[p] === expSuper[p]) else begin
                $display("FAIL %0t: test %0d port %0d superPage %b, expected %b",
                    $time, testIds[p], p, superOut[p], expSuper[p]);
                errs++;
            end
        end
        if (errs == 0) begin
            $display("test %0d port %0d: passed", testIds[p], p);
        end else begin
            $display("test %0d port %0d: failed", testIds[p], p);
            testsFailed++;
        end
    endtask

    // four-phase handshake on every port in the mask at once
    task automatic runGroup(input logic [2:0] mask);
        logic [2:0] done;
        done = 3'b000;
        reqs = mask;
        while (done != mask) begin
            nextCycle();
            for (int p = 0; p < 3; p++) begin
                if (mask[p] && !done[p] && acks[p]) begin
                    checkPort(p);
                    reqs[p] = 1'b0;
                    done[p] = 1'b1;
                end else if (!mask[p] && acks[p]) begin
                    $display("port %0d raised ack without a request at %0t", p, $time);
                    otherErrors++;
                end
            end
        end
        while (acks != 3'b000) nextCycle();
    endtask

    task automatic runStim();
        int fd;
        string line;
        logic [31:0] addrIn, dataIn, vaddrIn, rootIn, ppnIn;
        int srcIn, privIn, sumIn, mxrIn, maskIn, spIn, pfIn;
        int readyMask;
        readyMask = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            otherErrors++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") continue;
            if (line[0] == "W" && $sscanf(line, "W %h %h", addrIn, dataIn) == 2) begin
                writeWord(addrIn, dataIn);
            end else if (line[0] == "T" && $sscanf(line, "T %d %d %d %d %h %h %d %h %d %d",
                    srcIn, privIn, sumIn, mxrIn, rootIn, vaddrIn, maskIn, ppnIn, spIn, pfIn) == 10
                    && srcIn >= 0 && srcIn < 3) begin
                vaddrs[srcIn] = vaddrIn;
                rootPpns[srcIn] = rootIn[21:0];
                privs[srcIn] = mmuPkg::PrivLevel'(privIn[1:0]);
                sums[srcIn] = sumIn[0];
                mxrs[srcIn] = mxrIn[0];
                expPpn[srcIn] = ppnIn[21:0];
                expSuper[srcIn] = spIn[0];
                expFault[srcIn] = pfIn[0];
                testsRun++;
                testIds[srcIn] = testsRun;
                readyMask |= 1 << srcIn;
                if (readyMask == maskIn) begin  // group complete
                    runGroup(maskIn[2:0]);
                    readyMask = 0;
                end
            end else begin
                $display("stimulus line could not be read: %s", line);
                otherErrors++;
            end
        end
        if (readyMask != 0) begin
            $display("stimulus ended before a port group was complete");
            otherErrors++;
        end
        $fclose(fd);
    endtask

    initial begin
        int nTests;
        int nWrites;
        rst = 1'b1;
        reqs = '0;
        sums = '0;
        mxrs = '0;
        for (int p = 0; p < 3; p++) begin
            vaddrs[p] = '0;
            rootPpns[p] = '0;
            privs[p] = mmuPkg::PRIV_MACHINE;
        end
        memWe = 1'b0;
        memWaddr = '0;
        memWdata = '0;
        testsRun = 0;
        testsFailed = 0;
        otherErrors = 0;
        countLines(nTests, nWrites);
        cycleLimit = nTests * CYCLES_PER_TEST + nWrites;
        repeat (3) nextCycle();
        rst = 1'b0;
        runStim();
        $display("tests run %0d, passed %0d, failed %0d, other errors %0d",
            testsRun, testsRun - testsFailed, testsFailed, otherErrors);
        if (testsFailed == 0 && otherErrors == 0 && testsRun > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/walkStim.txt ====
# W byteAddr data : page-table word write, both hex
# T src priv sum mxr rootPpn vaddr mask ppn super fault : rootPpn, vaddr, ppn hex
# src 0 ifetch 1 store 2 load; priv 0 user 1 supervisor 3 machine; mask has one bit per port
# level-1 table at 0x1000: pointer, superpage, misaligned superpage, illegal pointer
W 00001000 00000801
W 00001004 001000CF
W 00001008 001004CF
W 0000100C 00004001
# level-0 table at 0x2000: RX, RW, R, X, URWX, V clear, A clear, D clear, W only
W 00002000 0004004B
W 00002004 000404C7
W 00002008 000408C3
W 0000200C 00040C49
W 00002010 000410DF
W 00002014 000414CE
W 00002018 0004188F
W 0000201C 00041C47
W 00002020 000420C5
T 0 1 0 0 000001 00000123 1 000100 0 0
T 1 1 0 0 000001 00001abc 2 000101 0 0
T 2 1 0 0 000001 00002ff0 4 000102 0 0
T 2 3 0 0 000001 00412345 4 000400 1 0
T 0 1 0 0 000001 00812345 1 000000 0 1
T 1 1 0 0 000001 00002000 2 000000 0 1
T 0 1 0 0 000001 00001000 1 000000 0 1
T 2 1 0 0 000001 00003000 4 000000 0 1
T 2 1 0 1 000001 00003000 4 000103 0 0
T 2 0 0 0 000001 00002000 4 000000 0 1
T 2 1 0 0 000001 00004000 4 000000 0 1
T 2 1 1 0 000001 00004000 4 000104 0 0
T 0 0 0 0 000001 00004000 1 000104 0 0
T 2 1 0 0 000001 00005000 4 000000 0 1
T 2 1 0 0 000001 00006000 4 000000 0 1
T 1 1 0 0 000001 00007000 2 000000 0 1
T 2 1 0 0 000001 00007000 4 000107 0 0
T 2 1 0 0 000001 00008000 4 000000 0 1
T 1 3 0 0 000001 00008000 2 000000 0 1
T 2 1 0 0 000001 00c00000 4 000000 0 1
# all three ports raise req together
T 0 1 0 0 000001 00000000 7 000100 0 0
T 1 1 0 0 000001 00001000 7 000101 0 0
T 2 3 0 0 000001 00400000 7 000400 1 0
